//--- ntt_pkg.sv
// ----------------------------------------
// Shared NTT definitions
// Modulus, widths and batch size
// Constant twiddle table per stage
// Error bit enumeration
// ----------------------------------------
package ntt_pkg;

  // Arithmetic
  localparam int unsigned COEF_W   = 13;
  localparam int unsigned MOD_Q    = 7681;
  localparam int unsigned MULT_LAT = 2;

  // Stream shape
  localparam int unsigned PBS_ID_W    = 4;
  localparam int unsigned BATCH_PAIRS = 4;

  typedef logic [COEF_W-1:0] coef_t;

  // Twiddles indexed by absolute stage and pair position
  localparam int unsigned TWD_STAGE_MAX = 8;

  localparam coef_t TWD_ROM [TWD_STAGE_MAX][BATCH_PAIRS] = '{
    '{13'd1,    13'd3383, 13'd4298, 13'd1213},
    '{13'd17,   13'd3449, 13'd1583, 13'd7154},
    '{13'd289,  13'd4112, 13'd5756, 13'd2028},
    '{13'd4913, 13'd945,  13'd6009, 13'd3733},
    '{13'd6711, 13'd2361, 13'd2138, 13'd2002},
    '{13'd6193, 13'd1732, 13'd5623, 13'd3125},
    '{13'd5408, 13'd6073, 13'd3415, 13'd7047},
    '{13'd7585, 13'd1042, 13'd2371, 13'd4350}
  };

  // Error word bits
  typedef enum int unsigned {
    ERR_BSK_MISS = 0
  } ntt_err_e;

  localparam int unsigned ERR_NB = 1;

endpackage

//--- ntt_stream_if.sv
// ----------------------------------------
// Coefficient pair stream
// Pair data with avail, batch flags and id
// ----------------------------------------
`timescale 1ns/1ps

interface ntt_stream_if
  import ntt_pkg::*;
();

  coef_t [1:0]         data;
  logic                avail;
  logic                sob;
  logic                eob;
  logic [PBS_ID_W-1:0] pbs_id;

  // Producer side
  modport src (
    output data,
    output avail,
    output sob,
    output eob,
    output pbs_id
  );

  // Consumer side
  modport dst (
    input  data,
    input  avail,
    input  sob,
    input  eob,
    input  pbs_id
  );

endinterface

//--- mod_mult.sv
// ----------------------------------------
// Pipelined modular multiplier
// Full product, then reduction mod Q
// ----------------------------------------
`timescale 1ns/1ps

module mod_mult
  import ntt_pkg::*;
(
  input  logic  clk,
  input  coef_t a,
  input  coef_t b,
  output coef_t p
);

  localparam int unsigned PROD_W = 2 * COEF_W;

  logic [PROD_W-1:0] prod_q;

  // Stage 1: raw product
  always_ff @(posedge clk) begin
    prod_q <= a * b;
  end

  // Stage 2: reduce by the constant modulus
  always_ff @(posedge clk) begin
    p <= coef_t'(prod_q % MOD_Q);
  end

endmodule

//--- ntt_bfly_stage.sv
// ----------------------------------------
// Radix-2 butterfly stage
// Twiddle picked by position in batch
// Outputs a+wb and a-wb mod Q
// ----------------------------------------
`timescale 1ns/1ps

module ntt_bfly_stage
  import ntt_pkg::*;
#(
  parameter int unsigned STAGE_ID = 0
)
(
  input  logic             clk,
  input  logic             s_rst_n,
  ntt_stream_if.dst        in_s,
  ntt_stream_if.src        out_s
);

  localparam int unsigned POS_W = $clog2(BATCH_PAIRS);
  localparam logic [COEF_W:0] Q_EXT = (COEF_W+1)'(MOD_Q);

  // ----------------------------------------
  // Pair position and twiddle
  // ----------------------------------------
  logic [POS_W-1:0] pos_q;
  logic [POS_W-1:0] cur_pos;
  coef_t            twd;

  // sob restarts the count on the current pair
  assign cur_pos = in_s.sob ? '0 : pos_q;
  assign twd     = TWD_ROM[STAGE_ID][cur_pos];

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      pos_q <= '0;
    end else if (in_s.avail) begin
      pos_q <= cur_pos + 1'b1;
    end
  end

  // ----------------------------------------
  // w*b and matching delay of a
  // ----------------------------------------
  coef_t wb;

  mod_mult mult_i (
    .clk (clk),
    .a   (in_s.data[1]),
    .b   (twd),
    .p   (wb)
  );

  logic  [MULT_LAT-1:0]               avail_dly;
  logic  [MULT_LAT-1:0]               sob_dly;
  logic  [MULT_LAT-1:0]               eob_dly;
  logic  [MULT_LAT-1:0][PBS_ID_W-1:0] pbs_id_dly;
  coef_t [MULT_LAT-1:0]               a_dly;

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      avail_dly <= '0;
    end else begin
      avail_dly <= {avail_dly[MULT_LAT-2:0], in_s.avail};
    end
  end

  always_ff @(posedge clk) begin
    sob_dly    <= {sob_dly[MULT_LAT-2:0], in_s.sob};
    eob_dly    <= {eob_dly[MULT_LAT-2:0], in_s.eob};
    pbs_id_dly <= {pbs_id_dly[MULT_LAT-2:0], in_s.pbs_id};
    a_dly      <= {a_dly[MULT_LAT-2:0], in_s.data[0]};
  end

  // ----------------------------------------
  // Butterfly add and subtract
  // ----------------------------------------
  logic [COEF_W:0] sum;
  logic [COEF_W:0] dif;
  coef_t           sum_red;
  coef_t           dif_red;

  // Both stay below 2Q, so one conditional subtract is enough
  assign sum     = {1'b0, a_dly[MULT_LAT-1]} + {1'b0, wb};
  assign dif     = {1'b0, a_dly[MULT_LAT-1]} + Q_EXT - {1'b0, wb};
  assign sum_red = coef_t'((sum >= Q_EXT) ? sum - Q_EXT : sum);
  assign dif_red = coef_t'((dif >= Q_EXT) ? dif - Q_EXT : dif);

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      out_s.avail <= 1'b0;
    end else begin
      out_s.avail <= avail_dly[MULT_LAT-1];
    end
  end

  always_ff @(posedge clk) begin
    out_s.data[0] <= sum_red;
    out_s.data[1] <= dif_red;
    out_s.sob     <= sob_dly[MULT_LAT-1];
    out_s.eob     <= eob_dly[MULT_LAT-1];
    out_s.pbs_id  <= pbs_id_dly[MULT_LAT-1];
  end

endmodule

//--- ntt_pointwise_mult.sv
// ----------------------------------------
// Point-wise multiply by key pair
// Valid/ready key intake
// Missing key detection
// ----------------------------------------
`timescale 1ns/1ps

module ntt_pointwise_mult
  import ntt_pkg::*;
(
  input  logic        clk,
  input  logic        s_rst_n,
  ntt_stream_if.dst   in_s,
  ntt_stream_if.src   out_s,
  input  coef_t [1:0] bsk,
  input  logic        bsk_vld,
  output logic        bsk_rdy,
  output logic        miss
);

  // ----------------------------------------
  // Key intake
  // ----------------------------------------
  coef_t [1:0] key_op;
  coef_t [1:0] prod;

  // A key is requested for every arriving pair
  assign bsk_rdy = in_s.avail;
  assign miss    = in_s.avail & ~bsk_vld;

  // Absent key counts as zero
  assign key_op[0] = bsk_vld ? bsk[0] : '0;
  assign key_op[1] = bsk_vld ? bsk[1] : '0;

  // ----------------------------------------
  // Multipliers
  // ----------------------------------------
  for (genvar i = 0; i < 2; i++) begin : gen_mult
    mod_mult mult_i (
      .clk (clk),
      .a   (in_s.data[i]),
      .b   (key_op[i]),
      .p   (prod[i])
    );
  end

  assign out_s.data = prod;

  // Control follows the multiplier latency
  logic [MULT_LAT-1:0]               avail_dly;
  logic [MULT_LAT-1:0]               sob_dly;
  logic [MULT_LAT-1:0]               eob_dly;
  logic [MULT_LAT-1:0][PBS_ID_W-1:0] pbs_id_dly;

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      avail_dly <= '0;
    end else begin
      avail_dly <= {avail_dly[MULT_LAT-2:0], in_s.avail};
    end
  end

  always_ff @(posedge clk) begin
    sob_dly    <= {sob_dly[MULT_LAT-2:0], in_s.sob};
    eob_dly    <= {eob_dly[MULT_LAT-2:0], in_s.eob};
    pbs_id_dly <= {pbs_id_dly[MULT_LAT-2:0], in_s.pbs_id};
  end

  assign out_s.avail  = avail_dly[MULT_LAT-1];
  assign out_s.sob    = sob_dly[MULT_LAT-1];
  assign out_s.eob    = eob_dly[MULT_LAT-1];
  assign out_s.pbs_id = pbs_id_dly[MULT_LAT-1];

endmodule

//--- ntt_core_middle.sv
// ----------------------------------------
// Middle NTT core
// Chain of butterfly stages
// Followed by key point-wise multiply
// ----------------------------------------
`timescale 1ns/1ps

module ntt_core_middle
  import ntt_pkg::*;
#(
  parameter int unsigned S_INIT = 0,
  parameter int unsigned S_NB   = 3
)
(
  input  logic              clk,
  input  logic              s_rst_n,
  ntt_stream_if.dst         in_s,
  ntt_stream_if.src         out_s,
  input  coef_t [1:0]       bsk,
  input  logic              bsk_vld,
  output logic              bsk_rdy,
  output logic [ERR_NB-1:0] err
);

  // Output of each butterfly stage
  ntt_stream_if stg_s [S_NB] ();

  logic miss;

  // ----------------------------------------
  // Butterfly chain
  // ----------------------------------------
  for (genvar i = 0; i < S_NB; i++) begin : gen_stage
    if (i == 0) begin : gen_first
      ntt_bfly_stage #(
        .STAGE_ID (S_INIT)
      ) stage_i (
        .clk     (clk),
        .s_rst_n (s_rst_n),
        .in_s    (in_s),
        .out_s   (stg_s[0])
      );
    end else begin : gen_next
      ntt_bfly_stage #(
        .STAGE_ID (S_INIT + i)
      ) stage_i (
        .clk     (clk),
        .s_rst_n (s_rst_n),
        .in_s    (stg_s[i-1]),
        .out_s   (stg_s[i])
      );
    end
  end

  // ----------------------------------------
  // Key multiply
  // ----------------------------------------
  ntt_pointwise_mult pwm_i (
    .clk     (clk),
    .s_rst_n (s_rst_n),
    .in_s    (stg_s[S_NB-1]),
    .out_s   (out_s),
    .bsk     (bsk),
    .bsk_vld (bsk_vld),
    .bsk_rdy (bsk_rdy),
    .miss    (miss)
  );

  always_comb begin
    err               = '0;
    err[ERR_BSK_MISS] = miss;
  end

endmodule

//--- pe_pbs_ntt_middle.sv
// ----------------------------------------
// PBS processing element, NTT middle part
// Input register, NTT core
// Registered error word
// ----------------------------------------
`timescale 1ns/1ps

module pe_pbs_ntt_middle
  import ntt_pkg::*;
#(
  parameter int unsigned S_INIT = 0,
  parameter int unsigned S_NB   = 3
)
(
  input  logic                clk,
  input  logic                s_rst_n,
  // From previous part
  input  coef_t [1:0]         prev_data,
  input  logic                prev_avail,
  input  logic                prev_sob,
  input  logic                prev_eob,
  input  logic [PBS_ID_W-1:0] prev_pbs_id,
  // Bootstrap key
  input  coef_t [1:0]         bsk,
  input  logic                bsk_vld,
  output logic                bsk_rdy,
  // To next part
  output coef_t [1:0]         next_data,
  output logic                next_avail,
  output logic                next_sob,
  output logic                next_eob,
  output logic [PBS_ID_W-1:0] next_pbs_id,
  // Error word
  output logic [ERR_NB-1:0]   pep_error
);

  ntt_stream_if in_s ();
  ntt_stream_if out_s ();

  logic [ERR_NB-1:0] err;

  // ----------------------------------------
  // Input register
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      in_s.avail <= 1'b0;
    end else begin
      in_s.avail <= prev_avail;
    end
  end

  always_ff @(posedge clk) begin
    in_s.data   <= prev_data;
    in_s.sob    <= prev_sob;
    in_s.eob    <= prev_eob;
    in_s.pbs_id <= prev_pbs_id;
  end

  // ----------------------------------------
  // Core
  // ----------------------------------------
  ntt_core_middle #(
    .S_INIT (S_INIT),
    .S_NB   (S_NB)
  ) core_i (
    .clk     (clk),
    .s_rst_n (s_rst_n),
    .in_s    (in_s),
    .out_s   (out_s),
    .bsk     (bsk),
    .bsk_vld (bsk_vld),
    .bsk_rdy (bsk_rdy),
    .err     (err)
  );

  assign next_data   = out_s.data;
  assign next_avail  = out_s.avail;
  assign next_sob    = out_s.sob;
  assign next_eob    = out_s.eob;
  assign next_pbs_id = out_s.pbs_id;

  // Error pulse one cycle after the event
  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      pep_error <= '0;
    end else begin
      pep_error <= err;
    end
  end

endmodule

//--- tb_clk_gen.sv
// ----------------------------------------
// Testbench clock source, 40 ns period
// ----------------------------------------
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter realtime HALF_PERIOD = 20.0
)
(
  output logic clk
);

  initial clk = 1'b0;

  always #(HALF_PERIOD) clk = ~clk;

endmodule

//--- tb_pe_pbs_ntt_middle.sv
// ----------------------------------------
// Testbench for the NTT middle PE
// Pattern driver, key feeder
// Output scoreboard, error and latency checks
// ----------------------------------------
`timescale 1ns/1ps

module tb_pe_pbs_ntt_middle
  import ntt_pkg::*;
();

  localparam int S_INIT  = 0;
  localparam int S_NB    = 3;
  localparam int LAT_EXP = 3 * S_NB + 3;
  localparam int NREC    = 16;
  localparam int REC_W   = 8;

  // Record columns
  localparam int F_D0  = 0;
  localparam int F_D1  = 1;
  localparam int F_K0  = 2;
  localparam int F_K1  = 3;
  localparam int F_KP  = 4;
  localparam int F_GAP = 5;
  localparam int F_E0  = 6;
  localparam int F_E1  = 7;

  logic                clk;
  logic                s_rst_n;
  coef_t [1:0]         prev_data;
  logic                prev_avail;
  logic                prev_sob;
  logic                prev_eob;
  logic [PBS_ID_W-1:0] prev_pbs_id;
  coef_t [1:0]         bsk;
  logic                bsk_vld;
  logic                bsk_rdy;
  coef_t [1:0]         next_data;
  logic                next_avail;
  logic                next_sob;
  logic                next_eob;
  logic [PBS_ID_W-1:0] next_pbs_id;
  logic [ERR_NB-1:0]   pep_error;

  logic [15:0] pat_mem [NREC*REC_W];

  int cycle   = 0;
  int limit;
  int out_idx = 0;
  int first_in_cycle;
  bit in_seen  = 1'b0;
  bit err_exp  = 1'b0;
  bit err_prev = 1'b0;

  tb_clk_gen clk_gen_i (
    .clk (clk)
  );

  pe_pbs_ntt_middle #(
    .S_INIT (S_INIT),
    .S_NB   (S_NB)
  ) dut_i (
    .clk         (clk),
    .s_rst_n     (s_rst_n),
    .prev_data   (prev_data),
    .prev_avail  (prev_avail),
    .prev_sob    (prev_sob),
    .prev_eob    (prev_eob),
    .prev_pbs_id (prev_pbs_id),
    .bsk         (bsk),
    .bsk_vld     (bsk_vld),
    .bsk_rdy     (bsk_rdy),
    .next_data   (next_data),
    .next_avail  (next_avail),
    .next_sob    (next_sob),
    .next_eob    (next_eob),
    .next_pbs_id (next_pbs_id),
    .pep_error   (pep_error)
  );

  function automatic int unsigned rec_field(int r, int f);
    return 32'(pat_mem[r*REC_W+f]);
  endfunction

  task automatic check_val(string name, int unsigned exp_v, int unsigned act_v);
    if (exp_v !== act_v) begin
      $display("CHECK FAILED at %0t: %s expected %0h got %0h", $time, name, exp_v, act_v);
      $display("test failed");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  // ----------------------------------------
  // Output monitor and scoreboard
  // ----------------------------------------
  always @(posedge clk) begin
    cycle++;
    if (cycle > limit) begin
      $display("Timeout: only %0d of %0d outputs seen after %0d cycles", out_idx, NREC, cycle);
      $display("test failed");
      $fatal(1, "simulation timed out");
    end
    if (s_rst_n) begin
      // Quiet outputs until the first pair goes in
      if (!in_seen) begin
        check_val("next_avail", 0, 32'(next_avail));
        check_val("bsk_rdy", 0, 32'(bsk_rdy));
        check_val("pep_error", 0, 32'(pep_error));
      end
      if (prev_avail && !in_seen) begin
        in_seen        = 1'b1;
        first_in_cycle = cycle;
      end
      // Error pulse one cycle ahead of the pair whose key was missing
      err_exp = next_avail && out_idx < NREC && rec_field(out_idx, F_KP) == 0;
      check_val("pep_error", 32'(err_exp), 32'(err_prev));
      err_prev = pep_error[ERR_BSK_MISS];
      if (next_avail) begin
        if (out_idx >= NREC) begin
          $display("Output pair appeared after all expected pairs were seen");
          $display("test failed");
          $fatal(1, "extra output");
        end
        if (out_idx == 0) begin
          check_val("latency", LAT_EXP, 32'(cycle - first_in_cycle));
        end
        check_val("next_data[0]", rec_field(out_idx, F_E0), 32'(next_data[0]));
        check_val("next_data[1]", rec_field(out_idx, F_E1), 32'(next_data[1]));
        check_val("next_sob", 32'(out_idx % BATCH_PAIRS == 0), 32'(next_sob));
        check_val("next_eob", 32'(out_idx % BATCH_PAIRS == BATCH_PAIRS - 1), 32'(next_eob));
        check_val("next_pbs_id", 32'(out_idx / BATCH_PAIRS), 32'(next_pbs_id));
        out_idx++;
      end
    end
  end

  // ----------------------------------------
  // Key feeder, one record per bsk_rdy cycle
  // ----------------------------------------
  initial begin
    int  kidx;
    int  lead;
    bit  loaded;
    void'($urandom(32'h11aa));
    bsk     = '0;
    bsk_vld = 1'b0;
    kidx    = 0;
    lead    = 0;
    loaded  = 1'b0;
    forever begin
      @(posedge clk);
      if (s_rst_n && bsk_rdy) begin
        kidx++;
        loaded = 1'b0;
      end
      #2;
      if (!loaded && kidx < NREC) begin
        loaded = 1'b1;
        lead   = int'($urandom % 3);
      end
      if (loaded && rec_field(kidx, F_KP) != 0) begin
        // Lead time is cut short once the pair is already waiting
        if (lead > 0 && !bsk_rdy) begin
          lead--;
          bsk_vld = 1'b0;
        end else begin
          bsk_vld = 1'b1;
          bsk[0]  = coef_t'(rec_field(kidx, F_K0));
          bsk[1]  = coef_t'(rec_field(kidx, F_K1));
        end
      end else begin
        bsk_vld = 1'b0;
      end
    end
  end

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------
  initial begin
    int gaps;
    s_rst_n     = 1'b0;
    prev_data   = '0;
    prev_avail  = 1'b0;
    prev_sob    = 1'b0;
    prev_eob    = 1'b0;
    prev_pbs_id = '0;
    limit       = 1000;

    $readmemh("ntt_patterns.hex", pat_mem);
    gaps = 0;
    for (int r = 0; r < NREC; r++) begin
      gaps += int'(rec_field(r, F_GAP));
    end
    limit = (NREC + gaps) * 2 + 100;

    repeat (10) @(posedge clk);
    #2;
    s_rst_n = 1'b1;
    repeat (4) @(posedge clk);

    for (int r = 0; r < NREC; r++) begin
      for (int g = 0; g < int'(rec_field(r, F_GAP)); g++) begin
        @(posedge clk);
        #2;
        prev_avail = 1'b0;
      end
      @(posedge clk);
      #2;
      prev_avail   = 1'b1;
      prev_data[0] = coef_t'(rec_field(r, F_D0));
      prev_data[1] = coef_t'(rec_field(r, F_D1));
      prev_sob     = (r % BATCH_PAIRS == 0);
      prev_eob     = (r % BATCH_PAIRS == BATCH_PAIRS - 1);
      prev_pbs_id  = PBS_ID_W'(r / BATCH_PAIRS);
    end
    @(posedge clk);
    #2;
    prev_avail = 1'b0;

    wait (out_idx == NREC);
    repeat (3) @(posedge clk);
    $display("test passed");
    $finish;
  end

endmodule

//--- ntt_patterns.hex
// d0 d1 k0 k1 key_present gap_before exp0 exp1
// batches of 4 records, pbs_id is the batch index
0001 0000 0001 0001 1 0 0C03 1222
0001 0000 0002 0001 1 0 045F 09C4
0001 0000 0001 0003 1 0 148A 0583
0002 0000 0001 0001 1 0 144E 017B
// back-to-back batch
0002 0000 0001 0001 1 0 1806 0643
0001 0000 0003 0002 1 0 158F 1388
0001 0000 0002 0002 1 0 0B13 0DAD
0001 0000 0003 0003 1 0 0074 1139
// gaps between pairs
0001 0000 0003 0001 1 3 0608 1222
0001 0000 0001 0003 1 1 1130 1D4C
0002 0000 0001 0001 1 5 0B13 0DAD
0001 0000 0001 0002 1 2 0A27 017B
// missing key on the second pair
0001 0000 0001 0001 1 2 0C03 1222
0003 0000 0005 0005 0 0 0000 0000
0001 0000 0003 0001 1 0 019C 15D7
0001 0000 0001 0001 1 1 0A27 0FBE

//--- src.f
ntt_pkg.sv
ntt_stream_if.sv
mod_mult.sv
ntt_bfly_stage.sv
ntt_pointwise_mult.sv
ntt_core_middle.sv
pe_pbs_ntt_middle.sv
tb_clk_gen.sv
tb_pe_pbs_ntt_middle.sv

//--- Makefile
TOP = tb_pe_pbs_ntt_middle

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f src.f --top-module $(TOP)

sim:
	verilator --binary --timing -f src.f --top-module $(TOP) -o sim_$(TOP)
	out=$$(./obj_dir/sim_$(TOP)); echo "$$out"; echo "$$out" | grep -q "^test passed$$"

clean:
	rm -rf obj_dir
